/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_led_controller
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= TB PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, look for the pass line"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILE_LIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* common/led_params_pkg.sv */
// Key and LED counts, duty width, triangle period, divider limits and wave offsets
`default_nettype none

package led_params_pkg;

    // -------------------------------------------------------------------------
    // Counts
    // -------------------------------------------------------------------------
    localparam int num_music_keys = 6;
    localparam int num_mode_leds  = 4;
    localparam int num_channels   = 3;    // Red, green, blue
    localparam int num_waves      = 5;

    localparam int duty_width = 8;
    localparam logic [duty_width-1:0] full_duty = 8'd255;

    // Triangle phase runs 0 to 511, one step per clock
    localparam int wave_period = 512;

    // -------------------------------------------------------------------------
    // Colour divider range and step
    // -------------------------------------------------------------------------
    localparam logic [duty_width-1:0] div_min   = 8'd1;
    localparam logic [duty_width-1:0] div_max   = 8'd25;
    localparam logic [duty_width-1:0] div_step  = 8'd3;
    localparam logic [duty_width-1:0] div_reset = 8'd1;

    // Added to the base triangle, one per wave
    localparam logic [duty_width-1:0] wave_offsets [num_waves] = '{
        8'd0, 8'd15, 8'd30, 8'd45, 8'd60
    };

endpackage

`default_nettype wire

/* common/music_box_pkg.sv */
// Music box state codes, mode LED indices, trim key roles and the LED colour union
`default_nettype none

package music_box_pkg;

    // States from the music box state controller
    localparam int state_width = 5;
    localparam logic [state_width-1:0] state_idle     = 5'd0;
    localparam logic [state_width-1:0] state_song0    = 5'd1;
    localparam logic [state_width-1:0] state_song1    = 5'd2;
    localparam logic [state_width-1:0] state_play_rec = 5'd3;
    localparam logic [state_width-1:0] state_make_rec = 5'd4;

    // Mode LED positions on the panel
    localparam int mode_song0    = 0;
    localparam int mode_song1    = 1;
    localparam int mode_make_rec = 2;
    localparam int mode_play_rec = 3;

    // Top row raises a channel divider, bottom row lowers it
    localparam int raise_key_base = 0;
    localparam int lower_key_base = 3;

    // One RGB duty word, indexed by channel or by colour name
    typedef union packed {
        logic [led_params_pkg::num_channels-1:0][led_params_pkg::duty_width-1:0] ch;
        struct packed {
            logic [led_params_pkg::duty_width-1:0] blue;    // Channel 2
            logic [led_params_pkg::duty_width-1:0] green;   // Channel 1
            logic [led_params_pkg::duty_width-1:0] red;     // Channel 0
        } rgb;
    } led_color_u;

endpackage

`default_nettype wire

/* files.f */
common/led_params_pkg.sv
common/music_box_pkg.sv
verilog/color_trim.sv
verilog/triangle_wave_bank.sv
verilog/brightness_mixer.sv
verilog/pwm_bank.sv
verilog/led_controller.sv
verification/led_checker.sv
verification/tb_led_controller.sv

/* verification/led_checker.sv */
// Reference model of waves, dividers, duties and PWM, with per clock pin comparison
`default_nettype none

module led_checker (
    input  wire                                       CLK_10Khz,
    input  wire                                       reset_n,
    input  wire  [music_box_pkg::state_width-1:0]     state,
    input  wire  [led_params_pkg::num_music_keys-1:0] keys,
    input  wire  [led_params_pkg::num_music_keys-1:0][led_params_pkg::num_channels-1:0] music_pins,
    input  wire  [led_params_pkg::num_mode_leds-1:0]  mode_pins,
    output int                                        mismatch_count,
    output int                                        check_count
);
    timeunit 1ns;
    timeprecision 100ps;

    int         phase;
    int         count;                  // PWM frame position
    int         div [3];
    int         music_duty [6][3];
    int         mode_duty [4];
    logic [5:0] keys_prev;
    logic [5:0][2:0] exp_music;
    logic [3:0] exp_mode;
    int         errors = 0;
    int         checks = 0;

    assign mismatch_count = errors;
    assign check_count    = checks;

    // Triangle with offset, folded back under the top
    function automatic int wave_value(input int p, input int i);
        int base;
        int s;
        base = (p < 256) ? p : 511 - p;
        s    = base + int'(led_params_pkg::wave_offsets[i]);
        return (s > 255) ? 510 - s : s;
    endfunction

    function automatic int mode_value(input logic [4:0] st, input int p, input int m);
        case (st)
            music_box_pkg::state_idle:
                if (m == music_box_pkg::mode_song0 || m == music_box_pkg::mode_make_rec) begin
                    return wave_value(p, 3) / 2;
                end else begin
                    return wave_value(p, 4) / 2;
                end
            music_box_pkg::state_song0:    return (m == music_box_pkg::mode_song0) ? 255 : 0;
            music_box_pkg::state_song1:    return (m == music_box_pkg::mode_song1) ? 255 : 0;
            music_box_pkg::state_play_rec: return (m == music_box_pkg::mode_play_rec) ? 255 : 0;
            music_box_pkg::state_make_rec: return (m == music_box_pkg::mode_make_rec) ? 255 : 0;
            default:                       return 0;
        endcase
    endfunction

    function automatic logic expected_pin(input int cnt, input int duty);
        return cnt < duty;
    endfunction

    // ------------------------------------------------------------------------
    // Reference model clocked on the same edge as the DUT
    // ------------------------------------------------------------------------
    always @(posedge CLK_10Khz or negedge reset_n) begin
        if (!reset_n) begin
            phase     = 0;
            count     = 0;
            keys_prev = '1;
            exp_music = '0;
            exp_mode  = '0;
            for (int c = 0; c < 3; c++) div[c] = 1;
            for (int j = 0; j < 6; j++) music_duty[j] = '{0, 0, 0};
            for (int m = 0; m < 4; m++) mode_duty[m] = 0;
        end else begin
            for (int j = 0; j < 6; j++) begin
                for (int c = 0; c < 3; c++) exp_music[j][c] = expected_pin(count, music_duty[j][c]);
            end
            for (int m = 0; m < 4; m++) exp_mode[m] = expected_pin(count, mode_duty[m]);
            count = (count + 1) % 256;

            // Duties from the waves and dividers before this edge
            for (int j = 0; j < 6; j++) begin
                for (int c = 0; c < 3; c++) begin
                    if (state == music_box_pkg::state_idle ||
                        state == music_box_pkg::state_make_rec) begin
                        music_duty[j][c] = wave_value(phase, j % 3) / div[c];
                    end else begin
                        music_duty[j][c] = 0;
                    end
                end
            end
            for (int m = 0; m < 4; m++) mode_duty[m] = mode_value(state, phase, m);
            phase = (phase + 1) % 512;

            if (state == music_box_pkg::state_idle || state == music_box_pkg::state_make_rec) begin
                for (int c = 0; c < 3; c++) begin
                    if (keys_prev[3 + c] && !keys[3 + c] && div[c] > 1) begin
                        div[c] = div[c] - 3;
                    end else if (keys_prev[c] && !keys[c] && div[c] < 25) begin
                        div[c] = div[c] + 3;
                    end
                end
            end
            keys_prev = keys;   // Updated in every state
        end
    end

    // Compare away from the active edge
    always @(negedge CLK_10Khz) begin
        checks = checks + 1;
        for (int j = 0; j < 6; j++) begin
            for (int c = 0; c < 3; c++) begin
                if (music_pins[j][c] !== exp_music[j][c]) begin
                    errors = errors + 1;
                    $display("mismatch music_pins[%0d][%0d]: expected %h, actual %h",
                             j, c, exp_music[j][c], music_pins[j][c]);
                end
            end
        end
        for (int m = 0; m < 4; m++) begin
            if (mode_pins[m] !== exp_mode[m]) begin
                errors = errors + 1;
                $display("mismatch mode_pins[%0d]: expected %h, actual %h",
                         m, exp_mode[m], mode_pins[m]);
            end
        end
    end

endmodule

`default_nettype wire

/* verification/tb_led_controller.sv */
// Testbench top with clock, reset, LFSR stimulus, watchdog, DUT and checker instances
`default_nettype none

module tb_led_controller;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int idle_cycles      = 600;     // More than one triangle period
    localparam int num_segments     = 16;
    localparam int max_segment      = 320;     // 64 + 255 rounded up to whole patterns
    localparam int trim_cycles      = 3 * (23 * 4 + 22 + 100);
    localparam int mode_trim_cycles = 3 * 4;
    localparam int planned_cycles   = 4 + 2 * idle_cycles + trim_cycles + mode_trim_cycles
                                      + num_segments * max_segment + 8;

    logic                                      CLK_10Khz;
    logic                                      reset_n;
    logic [music_box_pkg::state_width-1:0]     state;
    logic [led_params_pkg::num_music_keys-1:0] keys;
    logic [led_params_pkg::num_music_keys-1:0][led_params_pkg::num_channels-1:0] music_pins;
    logic [led_params_pkg::num_mode_leds-1:0]  mode_pins;
    int                                        mismatch_count;
    int                                        check_count;
    logic [15:0]                               lfsr = 16'd75;

    led_controller i_dut (
        .CLK_10Khz  (CLK_10Khz),
        .reset_n    (reset_n),
        .state      (state),
        .keys       (keys),
        .music_pins (music_pins),
        .mode_pins  (mode_pins)
    );

    led_checker i_checker (
        .CLK_10Khz      (CLK_10Khz),
        .reset_n        (reset_n),
        .state          (state),
        .keys           (keys),
        .music_pins     (music_pins),
        .mode_pins      (mode_pins),
        .mismatch_count (mismatch_count),
        .check_count    (check_count)
    );

    initial begin
        CLK_10Khz = 1'b0;
        forever #5 CLK_10Khz = ~CLK_10Khz;
    end

    // Galois LFSR with taps 16, 14, 13 and 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsr_next(lfsr);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge CLK_10Khz);
    endtask

    // One press of key k, low for hold cycles, then two released cycles
    task automatic press_key(input int k, input int hold);
        keys[k] <= 1'b0;
        wait_cycles(hold);
        keys[k] <= 1'b1;
        wait_cycles(2);
    endtask

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial begin
        int pick;
        int dwell;
        int pattern;
        reset_n <= 1'b0;
        state   <= music_box_pkg::state_idle;
        keys    <= '1;
        wait_cycles(4);
        reset_n <= 1'b1;
        wait_cycles(idle_cycles);

        // Per channel run up to the top, one long hold, then down to the bottom
        for (int c = 0; c < led_params_pkg::num_channels; c++) begin
            repeat (10) press_key(music_box_pkg::raise_key_base + c, 2);
            press_key(music_box_pkg::lower_key_base + c, 20);   // Held, one step only
            wait_cycles(100);
            repeat (10) press_key(music_box_pkg::lower_key_base + c, 2);
            repeat (3) press_key(music_box_pkg::raise_key_base + c, 2);
        end

        // Make-recording still trims, a song state ignores the press
        state <= music_box_pkg::state_make_rec;
        press_key(music_box_pkg::raise_key_base, 2);
        press_key(music_box_pkg::lower_key_base + 1, 2);
        state <= music_box_pkg::state_song0;
        press_key(music_box_pkg::raise_key_base + 2, 2);

        // Random states with random key patterns every eight cycles
        for (int s = 0; s < num_segments; s++) begin
            take_bits(3, pick);
            take_bits(8, dwell);
            state <= 5'(pick % 5);
            for (int t = 0; t < 64 + dwell; t += 8) begin
                take_bits(6, pattern);
                keys <= 6'(pattern);
                wait_cycles(8);
            end
        end

        state <= music_box_pkg::state_idle;
        keys  <= '1;
        wait_cycles(idle_cycles);
        wait_cycles(2);   // Last compare has run by now

        $display("checks %0d, mismatches %0d", check_count, mismatch_count);
        if (mismatch_count == 0 && check_count > 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        #(2 * planned_cycles * 10);
        $display("timeout: stimulus did not finish within %0d cycles", 2 * planned_cycles);
        $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/brightness_mixer.sv */
// State dependent duty computation and duty registers for every key LED
`default_nettype none

module brightness_mixer (
    input  wire                                    CLK_10Khz,
    input  wire                                    reset_n,
    input  wire  [music_box_pkg::state_width-1:0]  state,
    input  wire  [led_params_pkg::num_waves-1:0][led_params_pkg::duty_width-1:0]    waves,
    input  wire  [led_params_pkg::num_channels-1:0][led_params_pkg::duty_width-1:0] dividers,
    output music_box_pkg::led_color_u [led_params_pkg::num_music_keys-1:0]          music_duty,
    output logic [led_params_pkg::num_mode_leds-1:0][led_params_pkg::duty_width-1:0] mode_duty
);

    music_box_pkg::led_color_u [led_params_pkg::num_music_keys-1:0]           music_next;
    logic [led_params_pkg::num_mode_leds-1:0][led_params_pkg::duty_width-1:0] mode_next;
    logic                                                                     animate;

    assign animate = (state == music_box_pkg::state_idle) ||
                     (state == music_box_pkg::state_make_rec);

    always_comb begin
        music_next = '0;
        mode_next  = '0;

        // Both panel rows reuse waves 0 to 2, one per column
        if (animate) begin
            for (int j = 0; j < led_params_pkg::num_music_keys; j++) begin
                for (int c = 0; c < led_params_pkg::num_channels; c++) begin
                    music_next[j].ch[c] = waves[j % led_params_pkg::num_channels] / dividers[c];
                end
            end
        end

        // ---------------------------------------------------------------------
        // Mode keys pulse at half brightness in idle and are solid otherwise
        // ---------------------------------------------------------------------
        case (state)
            music_box_pkg::state_idle: begin
                mode_next[music_box_pkg::mode_song0]    = waves[3] >> 1;
                mode_next[music_box_pkg::mode_make_rec] = waves[3] >> 1;
                mode_next[music_box_pkg::mode_song1]    = waves[4] >> 1;
                mode_next[music_box_pkg::mode_play_rec] = waves[4] >> 1;
            end
            music_box_pkg::state_song0:
                mode_next[music_box_pkg::mode_song0] = led_params_pkg::full_duty;
            music_box_pkg::state_song1:
                mode_next[music_box_pkg::mode_song1] = led_params_pkg::full_duty;
            music_box_pkg::state_play_rec:
                mode_next[music_box_pkg::mode_play_rec] = led_params_pkg::full_duty;
            music_box_pkg::state_make_rec:
                mode_next[music_box_pkg::mode_make_rec] = led_params_pkg::full_duty;
            default: ;   // Unknown codes stay dark
        endcase
    end

    always_ff @(posedge CLK_10Khz or negedge reset_n) begin
        if (!reset_n) begin
            music_duty <= '0;
            mode_duty  <= '0;
        end else begin
            music_duty <= music_next;
            mode_duty  <= mode_next;
        end
    end

endmodule

`default_nettype wire

/* verilog/color_trim.sv */
// Key press edge detection and the three colour divider registers
`default_nettype none

module color_trim (
    input  wire                                       CLK_10Khz,
    input  wire                                       reset_n,
    input  wire  [music_box_pkg::state_width-1:0]     state,
    input  wire  [led_params_pkg::num_music_keys-1:0] keys,     // Active low
    output logic [led_params_pkg::num_channels-1:0][led_params_pkg::duty_width-1:0] dividers
);

    logic [led_params_pkg::num_music_keys-1:0] keys_q;     // Previous sample
    logic [led_params_pkg::num_music_keys-1:0] pressed;
    logic                                      trim_en;

    // Falling edge on an active low key
    assign pressed = keys_q & ~keys;

    // Trimming only while the keys are not playing notes
    assign trim_en = (state == music_box_pkg::state_idle) ||
                     (state == music_box_pkg::state_make_rec);

    always_ff @(posedge CLK_10Khz or negedge reset_n) begin
        if (!reset_n) begin
            keys_q <= '1;
            for (int c = 0; c < led_params_pkg::num_channels; c++) begin
                dividers[c] <= led_params_pkg::div_reset;
            end
        end else begin
            keys_q <= keys;   // Sampled in every state
            if (trim_en) begin
                for (int c = 0; c < led_params_pkg::num_channels; c++) begin
                    // Lower wins when both keys of a channel hit together
                    if (pressed[music_box_pkg::lower_key_base + c] &&
                        dividers[c] > led_params_pkg::div_min) begin
                        dividers[c] <= dividers[c] - led_params_pkg::div_step;
                    end else if (pressed[music_box_pkg::raise_key_base + c] &&
                                 dividers[c] < led_params_pkg::div_max) begin
                        dividers[c] <= dividers[c] + led_params_pkg::div_step;   // Dimmer
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/led_controller.sv */
// Key light controller top level with colour trim, wave bank, mixer and PWM outputs
`default_nettype none

module led_controller (
    input  wire                                          CLK_10Khz,
    input  wire                                          reset_n,
    input  wire  [music_box_pkg::state_width-1:0]        state,
    input  wire  [led_params_pkg::num_music_keys-1:0]    keys,        // Active low
    output logic [led_params_pkg::num_music_keys-1:0][led_params_pkg::num_channels-1:0] music_pins,
    output logic [led_params_pkg::num_mode_leds-1:0]     mode_pins
);

    logic [led_params_pkg::num_channels-1:0][led_params_pkg::duty_width-1:0] dividers;
    logic [led_params_pkg::num_waves-1:0][led_params_pkg::duty_width-1:0]    waves;
    music_box_pkg::led_color_u [led_params_pkg::num_music_keys-1:0]          music_duty;
    logic [led_params_pkg::num_mode_leds-1:0][led_params_pkg::duty_width-1:0] mode_duty;

    // -------------------------------------------------------------------------
    // Input side
    // -------------------------------------------------------------------------
    color_trim i_color_trim (
        .CLK_10Khz (CLK_10Khz),
        .reset_n   (reset_n),
        .state     (state),
        .keys      (keys),
        .dividers  (dividers)
    );

    triangle_wave_bank i_triangle_wave_bank (
        .CLK_10Khz (CLK_10Khz),
        .reset_n   (reset_n),
        .waves     (waves)
    );

    // Duty registers run one clock behind waves and dividers
    brightness_mixer i_brightness_mixer (
        .CLK_10Khz  (CLK_10Khz),
        .reset_n    (reset_n),
        .state      (state),
        .waves      (waves),
        .dividers   (dividers),
        .music_duty (music_duty),
        .mode_duty  (mode_duty)
    );

    // -------------------------------------------------------------------------
    // Output side
    // -------------------------------------------------------------------------
    pwm_bank i_pwm_bank (
        .CLK_10Khz  (CLK_10Khz),
        .reset_n    (reset_n),
        .music_duty (music_duty),
        .mode_duty  (mode_duty),
        .music_pins (music_pins),
        .mode_pins  (mode_pins)
    );

endmodule

`default_nettype wire

/* verilog/pwm_bank.sv */
// Shared PWM counter and registered pin outputs for music and mode LEDs
`default_nettype none

module pwm_bank (
    input  wire  CLK_10Khz,
    input  wire  reset_n,
    input  wire  music_box_pkg::led_color_u [led_params_pkg::num_music_keys-1:0] music_duty,
    input  wire  [led_params_pkg::num_mode_leds-1:0][led_params_pkg::duty_width-1:0] mode_duty,
    output logic [led_params_pkg::num_music_keys-1:0][led_params_pkg::num_channels-1:0] music_pins,
    output logic [led_params_pkg::num_mode_leds-1:0] mode_pins
);

    logic [led_params_pkg::duty_width-1:0] count;

    always_ff @(posedge CLK_10Khz or negedge reset_n) begin
        if (!reset_n) begin
            count      <= '0;
            music_pins <= '0;
            mode_pins  <= '0;
        end else begin
            count <= count + 1'b1;   // 256 clock PWM frame

            // Pin order per key is R, G, B
            for (int j = 0; j < led_params_pkg::num_music_keys; j++) begin
                music_pins[j][0] <= count < music_duty[j].rgb.red;
                music_pins[j][1] <= count < music_duty[j].rgb.green;
                music_pins[j][2] <= count < music_duty[j].rgb.blue;
            end

            // Full duty still drops for one count per frame
            for (int m = 0; m < led_params_pkg::num_mode_leds; m++) begin
                mode_pins[m] <= count < mode_duty[m];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/triangle_wave_bank.sv */
// Shared phase counter and five phase shifted triangle waves
`default_nettype none

module triangle_wave_bank (
    input  wire  CLK_10Khz,
    input  wire  reset_n,
    output logic [led_params_pkg::num_waves-1:0][led_params_pkg::duty_width-1:0] waves
);

    logic [$clog2(led_params_pkg::wave_period)-1:0] phase;
    logic [led_params_pkg::duty_width-1:0]          base;
    logic [led_params_pkg::duty_width:0]            sum [led_params_pkg::num_waves];

    always_ff @(posedge CLK_10Khz or negedge reset_n) begin
        if (!reset_n) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;   // Wraps after 511
        end
    end

    // Upper half mirrors the lower half, ~p is 511 - p there
    assign base = phase[$high(phase)] ? ~phase[led_params_pkg::duty_width-1:0]
                                      :  phase[led_params_pkg::duty_width-1:0];

    // -------------------------------------------------------------------------
    // Offset and fold back into 0..255
    // -------------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < led_params_pkg::num_waves; i++) begin
            sum[i] = {1'b0, base} + {1'b0, led_params_pkg::wave_offsets[i]};
            if (sum[i] > {1'b0, led_params_pkg::full_duty}) begin
                // 510 - s reflects the overshoot off the top
                sum[i] = {led_params_pkg::full_duty, 1'b0} - sum[i];
            end
            waves[i] = sum[i][led_params_pkg::duty_width-1:0];
        end
    end

endmodule

`default_nettype wire
